//--- hdl/sd_cmd_pkg.sv
// ========================================
// SD command path shared definitions
// Frame lengths, request struct and the
// state encodings of both stages
// ========================================

package sd_cmd_pkg;

  // Command length ahead of the CRC
  localparam int CMD_BITS       = 40;
  localparam int CRC_BITS       = 7;

  // Response payload lengths, start bit included
  localparam int RSP_SHORT_BITS = 40;
  localparam int RSP_LONG_BITS  = 136;

  // Request as captured by the top level
  typedef struct packed {
    logic [CMD_BITS-1:0] cmd;
    logic                rsp_long;
  } sd_cmd_req_t;

  // Command transmit stage
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_CMD,
    TX_CRC,
    TX_END,
    TX_DONE
  } tx_state_t;

  // Response receive stage
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_WAIT_START,
    RX_PAYLOAD,
    RX_CRC,
    RX_CHECK,
    RX_FINISHED
  } rx_state_t;

endpackage

//--- hdl/sd_crc7.sv
// ========================================
// Serial CRC7 generator
// One bit per enabled clock, x^7 + x^3 + 1
// ========================================

`timescale 1ns/100ps

module sd_crc7 (
  input  logic                          i_sd_clk,
  input  logic                          rst,
  input  logic                          i_clear,
  input  logic                          i_en,
  input  logic                          i_bit,
  output logic [sd_cmd_pkg::CRC_BITS-1:0] o_crc
);

  logic fb;

  // Incoming bit against the top of the register
  assign fb = i_bit ^ o_crc[6];

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      o_crc <= '0;
    end else if (i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      // Feedback lands in bit 0 and bit 3
      o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb};
    end
  end

endmodule

//--- hdl/sd_cmd_tx.sv
// ========================================
// SD command transmit stage
// Serializes the command, its CRC7 and
// the end bit onto the command line
// ========================================

`timescale 1ns/100ps

module sd_cmd_tx (
  input  logic                    i_sd_clk,
  input  logic                    rst,
  input  logic                    i_abort,
  input  logic                    i_start,
  input  sd_cmd_pkg::sd_cmd_req_t i_req,
  output logic                    o_sd_cmd,
  output logic                    o_busy,
  output logic                    o_done
);

  import sd_cmd_pkg::*;

  localparam int CNT_W = $clog2(CMD_BITS);

  tx_state_t           state;
  logic [CMD_BITS-1:0] cmd_sr;
  logic [CNT_W-1:0]    bit_cnt;
  logic [CRC_BITS-1:0] crc;
  logic                crc_en;

  // The CRC sees each bit in the cycle it is on the line.
  // In TX_CRC it is fed its own top bit, so it just shifts left
  assign crc_en = (state == TX_CMD) || (state == TX_CRC);

  sd_crc7 u_crc (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (i_start),
    .i_en     (crc_en),
    .i_bit    (o_sd_cmd),
    .o_crc    (crc)
  );

  // Line is idle high outside the command and CRC bits
  always_comb begin
    case (state)
      TX_CMD:  o_sd_cmd = cmd_sr[CMD_BITS-1];
      TX_CRC:  o_sd_cmd = crc[CRC_BITS-1];
      default: o_sd_cmd = 1'b1;
    endcase
  end

  assign o_busy = (state != TX_IDLE);
  assign o_done = (state == TX_DONE);

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
    end else if (i_abort) begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          if (i_start) begin
            state <= TX_CMD;
          end
        end
        TX_CMD: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(CMD_BITS - 1)) begin
            bit_cnt <= '0;
            state   <= TX_CRC;
          end
        end
        TX_CRC: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(CRC_BITS - 1)) begin
            state <= TX_END;
          end
        end
        // End bit on the line
        TX_END:  state <= TX_DONE;
        TX_DONE: state <= TX_IDLE;
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Command shifter, MSB first
  always_ff @(posedge i_sd_clk) begin
    if (state == TX_IDLE && i_start) begin
      cmd_sr <= i_req.cmd;
    end else if (state == TX_CMD) begin
      cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
    end
  end

endmodule

//--- hdl/sd_rsp_rx.sv
// ========================================
// SD response receive stage
// Waits for the start bit, shifts in a
// short or long response, checks CRC7
// ========================================

`timescale 1ns/100ps

module sd_rsp_rx #(
  parameter int RSP_MAX_BITS = 136
) (
  input  logic                    i_sd_clk,
  input  logic                    rst,
  input  logic                    i_abort,
  input  logic                    i_start,
  input  logic                    i_rsp_long,
  input  logic                    i_sd_cmd,
  output logic [RSP_MAX_BITS-1:0] o_rsp,
  output logic                    o_crc_err,
  output logic                    o_done
);

  import sd_cmd_pkg::*;

  localparam int CNT_W = $clog2(RSP_LONG_BITS);

  rx_state_t           state;
  logic [CNT_W-1:0]    bit_cnt;
  logic [CNT_W-1:0]    last_bit;
  logic [CRC_BITS-1:0] crc_calc;
  logic [CRC_BITS-1:0] crc_rcv;
  logic                capture;

  assign last_bit = i_rsp_long ? CNT_W'(RSP_LONG_BITS - 1) :
                                 CNT_W'(RSP_SHORT_BITS - 1);

  // Start bit and payload both go into the response and the CRC
  assign capture = (state == RX_WAIT_START && !i_sd_cmd) ||
                   (state == RX_PAYLOAD);

  sd_crc7 u_crc (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (i_start),
    .i_en     (capture),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc_calc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      o_rsp     <= '0;
      o_crc_err <= 1'b0;
      o_done    <= 1'b0;
    end else if (i_abort) begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      o_crc_err <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      // Oldest bit ends up at the top, short frames right-aligned
      if (capture) begin
        o_rsp <= {o_rsp[RSP_MAX_BITS-2:0], i_sd_cmd};
      end
      case (state)
        RX_IDLE: begin
          if (i_start) begin
            o_rsp <= '0;
            state <= RX_WAIT_START;
          end
        end
        RX_WAIT_START: begin
          // No timeout, the card sets the pace
          if (!i_sd_cmd) begin
            bit_cnt <= CNT_W'(1);
            state   <= RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == last_bit) begin
            bit_cnt <= '0;
            state   <= RX_CRC;
          end
        end
        RX_CRC: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(CRC_BITS - 1)) begin
            state <= RX_CHECK;
          end
        end
        // End bit is on the line here and is ignored
        RX_CHECK: begin
          o_crc_err <= (crc_rcv != crc_calc);
          o_done    <= 1'b1;
          state     <= RX_FINISHED;
        end
        RX_FINISHED: state <= RX_FINISHED;
        default:     state <= RX_IDLE;
      endcase
    end
  end

  // CRC bits sent by the card
  always_ff @(posedge i_sd_clk) begin
    if (state == RX_CRC) begin
      crc_rcv <= {crc_rcv[CRC_BITS-2:0], i_sd_cmd};
    end
  end

endmodule

//--- hdl/sd_cmd_phy.sv
// ========================================
// SD host command path phy
// Captures a request, sends the command,
// receives the response, drives direction
// ========================================

`timescale 1ns/100ps

module sd_cmd_phy #(
  parameter int RSP_MAX_BITS = 136
) (
  input  logic                            i_sd_clk,
  input  logic                            rst,
  input  logic                            i_cmd_en,
  input  logic [sd_cmd_pkg::CMD_BITS-1:0] i_cmd,
  input  logic                            i_rsp_long,
  output logic [RSP_MAX_BITS-1:0]         o_rsp,
  output logic                            o_crc_err,
  output logic                            o_rsp_done,
  input  logic                            i_sd_cmd,
  output logic                            o_sd_cmd,
  output logic                            o_sd_cmd_dir
);

  import sd_cmd_pkg::*;

  sd_cmd_req_t req_q;
  logic        active;
  logic        start_q;
  logic        accept;
  logic        abort;
  logic        tx_busy;
  logic        tx_done;
  logic        dir_q;

  // Enable low takes every stage back to idle
  assign abort  = !i_cmd_en;
  assign accept = i_cmd_en && !active && !tx_busy;

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      active  <= 1'b0;
      start_q <= 1'b0;
      dir_q   <= 1'b1;
    end else begin
      start_q <= 1'b0;
      if (abort) begin
        active <= 1'b0;
        dir_q  <= 1'b1;
      end else begin
        if (accept) begin
          active  <= 1'b1;
          start_q <= 1'b1;
        end
        // Hand the line to the card after the turnaround cycle
        if (tx_done) begin
          dir_q <= 1'b0;
        end
      end
    end
  end

  // Request held for the whole transaction
  always_ff @(posedge i_sd_clk) begin
    if (accept) begin
      req_q.cmd      <= i_cmd;
      req_q.rsp_long <= i_rsp_long;
    end
  end

  // Host drives the line again once the response is complete
  assign o_sd_cmd_dir = dir_q | o_rsp_done;

  sd_cmd_tx u_tx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_abort  (abort),
    .i_start  (start_q),
    .i_req    (req_q),
    .o_sd_cmd (o_sd_cmd),
    .o_busy   (tx_busy),
    .o_done   (tx_done)
  );

  sd_rsp_rx #(
    .RSP_MAX_BITS (RSP_MAX_BITS)
  ) u_rx (
    .i_sd_clk   (i_sd_clk),
    .rst        (rst),
    .i_abort    (abort),
    .i_start    (tx_done),
    .i_rsp_long (req_q.rsp_long),
    .i_sd_cmd   (i_sd_cmd),
    .o_rsp      (o_rsp),
    .o_crc_err  (o_crc_err),
    .o_done     (o_rsp_done)
  );

endmodule

//--- bench/tb_clock.sv
// ========================================
// Testbench clock and reset
// 20 ns clock, reset held for two cycles
// ========================================

`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_NS      = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic o_sd_clk,
  output logic o_rst
);

  initial begin
    o_sd_clk = 1'b0;
    forever #HALF_NS o_sd_clk = ~o_sd_clk;
  end

  // Released just after an edge, like the other stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_sd_clk);
    #2 o_rst = 1'b0;
  end

endmodule

//--- bench/sd_cmd_phy_properties.sv
// ========================================
// Command line protocol assertions
// Bound into the SD command phy
// ========================================

`timescale 1ns/100ps

module sd_cmd_phy_properties (
  input logic i_sd_clk,
  input logic rst,
  input logic i_cmd_en,
  input logic i_line,
  input logic i_dir,
  input logic i_crc_err,
  input logic i_rsp_done
);

  // Line belongs to the card, host output stays idle
  a_line_idle_when_released: assert property (
    @(posedge i_sd_clk) disable iff (rst) !i_dir |-> i_line
  ) else $error("command line low while released to the card");

  a_crc_err_with_done: assert property (
    @(posedge i_sd_clk) disable iff (rst) i_crc_err |-> i_rsp_done
  ) else $error("crc error flag without response done");

  // Abort takes the line back on the next edge
  a_dir_after_abort: assert property (
    @(posedge i_sd_clk) disable iff (rst) !i_cmd_en |=> i_dir
  ) else $error("direction low one cycle after enable dropped");

endmodule

bind sd_cmd_phy sd_cmd_phy_properties u_props (
  .i_sd_clk   (i_sd_clk),
  .rst        (rst),
  .i_cmd_en   (i_cmd_en),
  .i_line     (o_sd_cmd),
  .i_dir      (o_sd_cmd_dir),
  .i_crc_err  (o_crc_err),
  .i_rsp_done (o_rsp_done)
);

//--- bench/sd_cmd_phy_tb.sv
// ========================================
// SD command phy testbench
// Directed tests against a simple card
// model with LFSR commands and payloads
// ========================================

`timescale 1ns/100ps

module sd_cmd_phy_tb;

  import sd_cmd_pkg::*;

  localparam int RSP_MAX_BITS = 136;
  localparam int WAIT_LIMIT   = 400;

  logic                    sd_clk;
  logic                    rst;
  logic                    cmd_en;
  logic [CMD_BITS-1:0]     cmd;
  logic                    rsp_long;
  logic [RSP_MAX_BITS-1:0] rsp;
  logic                    crc_err;
  logic                    rsp_done;
  logic                    line_in;
  logic                    line_out;
  logic                    dir;

  logic [31:0] lfsr;
  int          err_cnt;
  int          timeout_cnt;
  logic        cmd_bits[$];

  tb_clock #(.HALF_NS(10), .RESET_CYCLES(2)) u_clock (.o_sd_clk(sd_clk), .o_rst(rst));

  sd_cmd_phy #(
    .RSP_MAX_BITS (RSP_MAX_BITS)
  ) i_dut (
    .i_sd_clk     (sd_clk),
    .rst          (rst),
    .i_cmd_en     (cmd_en),
    .i_cmd        (cmd),
    .i_rsp_long   (rsp_long),
    .o_rsp        (rsp),
    .o_crc_err    (crc_err),
    .o_rsp_done   (rsp_done),
    .i_sd_cmd     (line_in),
    .o_sd_cmd     (line_out),
    .o_sd_cmd_dir (dir)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [135:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[134:0], lfsr[0]};
    end
  endtask

  // CRC7 over the low n bits taken MSB first with the register starting at zero
  function automatic logic [6:0] crc7_ref(input logic [135:0] data, input int n);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    end
    return crc;
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [135:0] exp, input logic [135:0] act);
    err_cnt++;
    $display("error %s: %s expected %h actual %h", test, what, exp, act);
  endtask

  task automatic drive_edge();
    @(posedge sd_clk);
    #2;
  endtask

  // Card side records the line while the host drives it
  task automatic capture_command(input string test, output logic ok);
    int n;
    cmd_bits.delete();
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge sd_clk);
      if (dir) begin
        cmd_bits.push_back(line_out);
      end else begin
        ok = 1'b1;
      end
      n++;
    end
    if (!ok) begin
      timeout_cnt++;
      $display("%s: direction never went low after the command", test);
    end
  endtask

  // Frame sits just before the turnaround bit
  task automatic check_frame(input string test, input logic [CMD_BITS-1:0] c);
    logic [CMD_BITS+CRC_BITS:0] exp_frame;
    logic [CMD_BITS+CRC_BITS:0] got;
    int                         base;
    exp_frame = {c, crc7_ref(136'(c), CMD_BITS), 1'b1};
    if (cmd_bits.size() < CMD_BITS + CRC_BITS + 2) begin
      err_cnt++;
      $display("%s: only %0d line bits seen with direction high", test, cmd_bits.size());
      return;
    end
    base = cmd_bits.size() - (CMD_BITS + CRC_BITS + 2);
    got  = '0;
    for (int i = 0; i < CMD_BITS + CRC_BITS + 1; i++) begin
      got = {got[CMD_BITS+CRC_BITS-1:0], cmd_bits[base+i]};
    end
    if (got !== exp_frame) begin
      report_mismatch(test, "command frame", 136'(exp_frame), 136'(got));
    end
    if (cmd_bits[cmd_bits.size()-1] !== 1'b1) begin
      report_mismatch(test, "turnaround bit", 136'(1), 136'(cmd_bits[cmd_bits.size()-1]));
    end
  endtask

  // Card answers after an idle gap with the payload, its CRC7 and the end bit
  task automatic send_response(input string test, input logic [135:0] payload,
                               input int nbits, input logic [6:0] crc_xor);
    logic [135:0] d;
    logic [6:0]   crc;
    int           gap;
    draw_bits(4, d);
    gap = int'(d[3:0]);
    crc = crc7_ref(payload, nbits) ^ crc_xor;
    for (int i = 0; i < gap; i++) begin
      drive_edge();
    end
    for (int i = nbits - 1; i >= 0; i--) begin
      drive_edge();
      line_in = payload[i];
    end
    for (int i = CRC_BITS - 1; i >= 0; i--) begin
      drive_edge();
      line_in = crc[i];
    end
    drive_edge();
    line_in = 1'b1;
    @(negedge sd_clk);
    if (rsp_done !== 1'b0) begin
      report_mismatch(test, "done during end bit", 136'(0), 136'(rsp_done));
    end
  endtask

  task automatic wait_rsp_done(input string test, output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge sd_clk);
      ok = rsp_done;
      n++;
    end
    if (!ok) begin
      timeout_cnt++;
      $display("%s: response done never came", test);
    end
  endtask

  task automatic run_transaction(input string test, input logic long_rsp,
                                 input logic corrupt);
    logic [135:0] c;
    logic [135:0] payload;
    logic [135:0] x;
    logic [6:0]   crc_xor;
    logic         ok;
    int           nbits;
    nbits = long_rsp ? RSP_LONG_BITS : RSP_SHORT_BITS;
    draw_bits(CMD_BITS, c);
    draw_bits(nbits, payload);
    // Start bit is the first payload bit
    payload[nbits-1] = 1'b0;
    crc_xor = '0;
    if (corrupt) begin
      draw_bits(CRC_BITS, x);
      crc_xor = (x[6:0] == 7'd0) ? 7'h01 : x[6:0];
    end
    drive_edge();
    cmd      = c[CMD_BITS-1:0];
    rsp_long = long_rsp;
    cmd_en   = 1'b1;
    capture_command(test, ok);
    if (!ok) begin
      return;
    end
    check_frame(test, c[CMD_BITS-1:0]);
    send_response(test, payload, nbits, crc_xor);
    wait_rsp_done(test, ok);
    if (!ok) begin
      return;
    end
    if (rsp !== payload[RSP_MAX_BITS-1:0]) begin
      report_mismatch(test, "response", payload, 136'(rsp));
    end
    if (crc_err !== corrupt) begin
      report_mismatch(test, "crc error", 136'(corrupt), 136'(crc_err));
    end
    if (dir !== 1'b1) begin
      report_mismatch(test, "direction at done", 136'(1), 136'(dir));
    end
    // Result is a level until enable falls
    @(negedge sd_clk);
    if (rsp_done !== 1'b1) begin
      report_mismatch(test, "done hold", 136'(1), 136'(rsp_done));
    end
  endtask

  task automatic release_request(input string test);
    drive_edge();
    cmd_en = 1'b0;
    @(posedge sd_clk);
    @(negedge sd_clk);
    if (rsp_done !== 1'b0) begin
      report_mismatch(test, "done after release", 136'(0), 136'(rsp_done));
    end
    if (dir !== 1'b1 || line_out !== 1'b1) begin
      report_mismatch(test, "dir and line after release", 136'(3), 136'({dir, line_out}));
    end
  endtask

  task automatic reset_state();
    int n;
    n = 0;
    while (rst && n < 20) begin
      @(posedge sd_clk);
      n++;
    end
    if (rst) begin
      timeout_cnt++;
      $display("reset: reset was never released");
      return;
    end
    @(negedge sd_clk);
    if (line_out !== 1'b1 || dir !== 1'b1) begin
      report_mismatch("reset", "line and dir", 136'(3), 136'({line_out, dir}));
    end
    if (rsp_done !== 1'b0 || crc_err !== 1'b0) begin
      report_mismatch("reset", "done and crc error", 136'(0), 136'({rsp_done, crc_err}));
    end
    if (rsp !== '0) begin
      report_mismatch("reset", "response", 136'(0), 136'(rsp));
    end
  endtask

  task automatic short_response();
    run_transaction("short_response", 1'b0, 1'b0);
    release_request("short_response");
  endtask

  task automatic long_response();
    run_transaction("long_response", 1'b1, 1'b0);
    release_request("long_response");
  endtask

  task automatic corrupted_crc();
    run_transaction("crc_error", 1'b0, 1'b1);
    release_request("crc_error");
  endtask

  task automatic abort_and_retry();
    logic [135:0] c;
    draw_bits(CMD_BITS, c);
    drive_edge();
    cmd      = c[CMD_BITS-1:0];
    rsp_long = 1'b0;
    cmd_en   = 1'b1;
    // Drop enable partway through the command frame
    repeat (20) drive_edge();
    cmd_en = 1'b0;
    @(posedge sd_clk);
    for (int i = 0; i < 8; i++) begin
      @(negedge sd_clk);
      if (line_out !== 1'b1 || dir !== 1'b1 || rsp_done !== 1'b0) begin
        report_mismatch("abort", "line dir done", 136'(6),
                        136'({line_out, dir, rsp_done}));
      end
    end
    run_transaction("abort_retry", 1'b0, 1'b0);
    release_request("abort_retry");
  endtask

  initial begin
    lfsr        = 32'hc8bfce5a;
    err_cnt     = 0;
    timeout_cnt = 0;
    cmd_en      = 1'b0;
    cmd         = '0;
    rsp_long    = 1'b0;
    line_in     = 1'b1;
    reset_state();
    short_response();
    long_response();
    corrupted_crc();
    abort_and_retry();
    $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/sd_cmd_pkg.sv
hdl/sd_crc7.sv
hdl/sd_cmd_tx.sv
hdl/sd_rsp_rx.sv
hdl/sd_cmd_phy.sv
bench/tb_clock.sv
bench/sd_cmd_phy_properties.sv
bench/sd_cmd_phy_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the SD command phy testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module sd_cmd_phy_tb \
  -f files.f \
  -o sim_tb

# The simulation may stop early on an assertion, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
